// File: msgq_macros.svh
`ifndef MSGQ_MACROS_SVH
`define MSGQ_MACROS_SVH

// host bus widths
`define MSGQ_ADDR_W 12
`define MSGQ_DATA_W 32

// credits the host holds after reset, also the request FIFO depth
`define MSGQ_REQ_CREDITS 4

// credits the DUT holds for the response channel
`define MSGQ_RSP_CREDITS 2

// each message queue holds 2**3 = 8 words
`define MSGQ_Q_DEPTH_LOG2 3

// address map, region sits in address bits 11..8
`define MSGQ_REGION_MSB 11
`define MSGQ_REGION_LSB 8
`define MSGQ_REGION_SYS 4'd0
`define MSGQ_REGION_Q0 4'd1
`define MSGQ_REGION_Q1 4'd2

`endif

// File: bus_pkg.sv
`include "msgq_macros.svh"

package bus_pkg;

	// one word request from the host
	typedef struct packed {
		logic is_write;
		logic [`MSGQ_ADDR_W-1:0] addr;
		logic [`MSGQ_DATA_W-1:0] wdata;
	} bus_req_t;

	// completion codes carried back with every response
	typedef enum logic [1:0] {
		ST_OK = 2'd0,
		ST_EMPTY = 2'd1,
		ST_FULL = 2'd2,
		ST_DECERR = 2'd3
	} bus_status_e;

	// one response per request, in request order
	typedef struct packed {
		logic [`MSGQ_DATA_W-1:0] rdata;
		bus_status_e status;
	} bus_rsp_t;

endpackage

// File: msgq_pkg.sv
`include "msgq_macros.svh"

package msgq_pkg;

	// status a queue reports to the register block and the decoder
	typedef struct packed {
		logic [`MSGQ_Q_DEPTH_LOG2:0] count;
		logic not_empty;
		logic full;
	} q_status_t;

	// steering from the register block into one queue
	typedef struct packed {
		logic flush;
	} q_ctrl_t;

endpackage

// File: credit_fifo.sv
module credit_fifo #(
	parameter type T = logic,
	parameter int DEPTH_LOG2 = 2
) (
	input logic core_clk,
	input logic rst_n,
	input logic i_push,
	input T i_data,
	input logic i_pop,
	output T o_data,
	output logic o_empty,
	output logic o_full,
	output logic o_credit
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	T mem [DEPTH];
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2:0] count;
	logic do_push;
	logic do_pop;

	assign o_empty = (count == '0);
	assign o_full = (count == DEPTH[DEPTH_LOG2:0]);
	// a full FIFO still takes a push in the cycle it pops an entry
	assign do_push = i_push & (~o_full | do_pop);
	assign do_pop = i_pop & ~o_empty;

	// head entry is visible without a pop
	assign o_data = mem[rd_ptr];

	// one credit goes back for every entry that leaves
	assign o_credit = do_pop;

	always_ff @(posedge core_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: msg_queue.sv
`include "msgq_macros.svh"

module msg_queue
	import msgq_pkg::*;
(
	input logic core_clk,
	input logic rst_n,
	input logic i_push,
	input logic i_pop,
	input logic [`MSGQ_DATA_W-1:0] i_wdata,
	input q_ctrl_t i_ctrl,
	output logic [`MSGQ_DATA_W-1:0] o_rdata,
	output q_status_t o_status
);

	localparam int AW = `MSGQ_Q_DEPTH_LOG2;
	localparam int DEPTH = 1 << AW;

	logic [`MSGQ_DATA_W-1:0] mem [DEPTH];
	logic [AW-1:0] head;
	logic [AW-1:0] tail;
	logic [AW:0] count;
	logic full;
	logic not_empty;
	logic do_push;
	logic do_pop;

	assign full = (count == DEPTH[AW:0]);
	assign not_empty = (count != '0);

	// full pushes and empty pops are dropped here as well
	assign do_push = i_push & ~full;
	assign do_pop = i_pop & not_empty;

	assign o_rdata = mem[head];

	always_comb begin
		o_status.count = count;
		o_status.not_empty = not_empty;
		o_status.full = full;
	end

	always_ff @(posedge core_clk) begin
		if (do_push) begin
			mem[tail] <= i_wdata;
		end
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (i_ctrl.flush) begin
			// flush wins over a push or pop in the same cycle
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				tail <= tail + 1'b1;
			end
			if (do_pop) begin
				head <= head + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: sys_regs.sv
`include "msgq_macros.svh"

module sys_regs
	import msgq_pkg::*;
(
	input logic core_clk,
	input logic rst_n,
	input logic i_wr,
	input logic i_rd,
	input logic [3:0] i_offset,
	input logic [`MSGQ_DATA_W-1:0] i_wdata,
	input q_status_t i_q0_status,
	input q_status_t i_q1_status,
	output logic [`MSGQ_DATA_W-1:0] o_rdata,
	output logic o_hit,
	output q_ctrl_t o_q0_ctrl,
	output q_ctrl_t o_q1_ctrl,
	output logic [3:0] o_led,
	output logic o_irq
);

	localparam logic [3:0] OFF_LED = 4'h0;
	localparam logic [3:0] OFF_IRQ_EN = 4'h4;
	localparam logic [3:0] OFF_IRQ_STAT = 4'h8;
	localparam logic [3:0] OFF_FLUSH = 4'hc;

	logic [3:0] led_q;
	logic [1:0] irq_en_q;
	logic [1:0] irq_stat;
	logic flush_wr;

	// a queue interrupts only while it holds data and is enabled
	assign irq_stat = {i_q1_status.not_empty, i_q0_status.not_empty} & irq_en_q;
	assign o_irq = |irq_stat;
	assign o_led = led_q;

	// flush acts in the write cycle so the next request sees empty queues
	assign flush_wr = i_wr & (i_offset == OFF_FLUSH);

	always_comb begin
		o_q0_ctrl.flush = flush_wr & i_wdata[0];
		o_q1_ctrl.flush = flush_wr & i_wdata[1];
	end

	always_comb begin
		o_rdata = '0;
		o_hit = 1'b0;
		case (i_offset)
			OFF_LED: begin
				o_rdata[3:0] = led_q;
				o_hit = i_wr | i_rd;
			end
			OFF_IRQ_EN: begin
				o_rdata[1:0] = irq_en_q;
				o_hit = i_wr | i_rd;
			end
			OFF_IRQ_STAT: begin
				o_rdata[1:0] = irq_stat;
				o_hit = i_rd;
			end
			// write only
			OFF_FLUSH: o_hit = i_wr;
			default: o_hit = 1'b0;
		endcase
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			led_q <= '0;
			irq_en_q <= '0;
		end else if (i_wr) begin
			if (i_offset == OFF_LED) begin
				led_q <= i_wdata[3:0];
			end
			if (i_offset == OFF_IRQ_EN) begin
				irq_en_q <= i_wdata[1:0];
			end
		end
	end

endmodule

// File: bus_decoder.sv
`include "msgq_macros.svh"

module bus_decoder
	import bus_pkg::*;
	import msgq_pkg::*;
(
	input logic core_clk,
	input logic rst_n,
	input bus_req_t i_req,
	input logic i_req_empty,
	output logic o_req_pop,
	input logic i_rsp_full,
	output logic o_rsp_push,
	output bus_rsp_t o_rsp,
	output logic o_q0_push,
	output logic o_q0_pop,
	output logic [`MSGQ_DATA_W-1:0] o_q0_wdata,
	output logic o_q1_push,
	output logic o_q1_pop,
	output logic [`MSGQ_DATA_W-1:0] o_q1_wdata,
	input logic [`MSGQ_DATA_W-1:0] i_q0_rdata,
	input logic [`MSGQ_DATA_W-1:0] i_q1_rdata,
	input q_status_t i_q0_status,
	input q_status_t i_q1_status,
	output logic o_sys_wr,
	output logic o_sys_rd,
	output logic [3:0] o_sys_offset,
	input logic [`MSGQ_DATA_W-1:0] i_sys_rdata,
	input logic i_sys_hit
);

	localparam logic [7:0] Q_OFF_DATA = 8'h00;
	localparam logic [7:0] Q_OFF_COUNT = 8'h04;

	logic [3:0] region;
	logic [7:0] offset;
	logic is_q0;
	logic is_q1;
	logic q_data;
	logic sys_sel;
	q_status_t q_stat;
	logic [`MSGQ_DATA_W-1:0] q_rdata;
	logic q_push_ok;
	logic q_pop_ok;
	bus_rsp_t rsp_d;

	// hold off while a response is still on its way into the response FIFO
	assign o_req_pop = ~i_req_empty & ~i_rsp_full & ~o_rsp_push;

	assign region = i_req.addr[`MSGQ_REGION_MSB:`MSGQ_REGION_LSB];
	assign offset = i_req.addr[`MSGQ_REGION_LSB-1:0];
	assign is_q0 = (region == `MSGQ_REGION_Q0);
	assign is_q1 = (region == `MSGQ_REGION_Q1);
	assign sys_sel = (region == `MSGQ_REGION_SYS) && (offset[7:4] == 4'h0);
	assign q_data = (is_q0 | is_q1) && (offset == Q_OFF_DATA);

	// pick the addressed queue once, then steer the action back
	assign q_stat = is_q1 ? i_q1_status : i_q0_status;
	assign q_rdata = is_q1 ? i_q1_rdata : i_q0_rdata;
	assign q_push_ok = o_req_pop & q_data & i_req.is_write & ~q_stat.full;
	assign q_pop_ok = o_req_pop & q_data & ~i_req.is_write & q_stat.not_empty;

	assign o_q0_push = q_push_ok & is_q0;
	assign o_q1_push = q_push_ok & is_q1;
	assign o_q0_pop = q_pop_ok & is_q0;
	assign o_q1_pop = q_pop_ok & is_q1;
	assign o_q0_wdata = i_req.wdata;
	assign o_q1_wdata = i_req.wdata;

	assign o_sys_wr = o_req_pop & sys_sel & i_req.is_write;
	assign o_sys_rd = o_req_pop & sys_sel & ~i_req.is_write;
	assign o_sys_offset = offset[3:0];

	always_comb begin
		rsp_d.rdata = '0;
		rsp_d.status = ST_OK;
		if (sys_sel) begin
			if (!i_sys_hit) begin
				rsp_d.status = ST_DECERR;
			end else if (!i_req.is_write) begin
				rsp_d.rdata = i_sys_rdata;
			end
		end else if (q_data) begin
			if (i_req.is_write) begin
				if (q_stat.full) begin
					rsp_d.status = ST_FULL;
				end
			end else if (q_stat.not_empty) begin
				rsp_d.rdata = q_rdata;
			end else begin
				rsp_d.status = ST_EMPTY;
			end
		end else if ((is_q0 | is_q1) && (offset == Q_OFF_COUNT)) begin
			// count is read only, a write just completes
			if (!i_req.is_write) begin
				rsp_d.rdata[`MSGQ_Q_DEPTH_LOG2:0] = q_stat.count;
			end
		end else begin
			rsp_d.status = ST_DECERR;
		end
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			o_rsp_push <= 1'b0;
		end else begin
			o_rsp_push <= o_req_pop;
		end
	end

	always_ff @(posedge core_clk) begin
		if (o_req_pop) begin
			o_rsp <= rsp_d;
		end
	end

endmodule

// File: msgq_sys_top.sv
`include "msgq_macros.svh"

module msgq_sys_top
	import bus_pkg::*;
	import msgq_pkg::*;
(
	input logic core_clk,
	input logic rst_n,
	input bus_req_t i_req,
	input logic i_req_valid,
	output logic o_req_credit,
	output bus_rsp_t o_rsp,
	output logic o_rsp_valid,
	input logic i_rsp_credit,
	output logic [3:0] o_led,
	output logic o_irq
);

	localparam int RSP_CW = $clog2(`MSGQ_RSP_CREDITS + 1);

	bus_req_t req_head;
	logic req_empty;
	logic req_pop;
	bus_rsp_t rsp_d;
	logic rsp_push;
	logic rsp_full;
	logic [RSP_CW-1:0] rsp_credits;
	logic q0_push, q0_pop, q1_push, q1_pop;
	logic [`MSGQ_DATA_W-1:0] q0_wdata, q1_wdata, q0_rdata, q1_rdata;
	q_status_t q0_status, q1_status;
	q_ctrl_t q0_ctrl, q1_ctrl;
	logic sys_wr, sys_rd, sys_hit;
	logic [3:0] sys_offset;
	logic [`MSGQ_DATA_W-1:0] sys_rdata;

	// host credits keep the request FIFO from overflowing
	credit_fifo #(.T(bus_req_t), .DEPTH_LOG2($clog2(`MSGQ_REQ_CREDITS))) u_req_fifo (
		.core_clk(core_clk), .rst_n(rst_n), .i_push(i_req_valid), .i_data(i_req),
		.i_pop(req_pop), .o_data(req_head), .o_empty(req_empty), .o_full(),
		.o_credit(o_req_credit));

	// head goes out whenever a response credit is held
	credit_fifo #(.T(bus_rsp_t), .DEPTH_LOG2($clog2(`MSGQ_RSP_CREDITS))) u_rsp_fifo (
		.core_clk(core_clk), .rst_n(rst_n), .i_push(rsp_push), .i_data(rsp_d),
		.i_pop(rsp_credits != '0), .o_data(o_rsp), .o_empty(), .o_full(rsp_full),
		.o_credit(o_rsp_valid));

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			rsp_credits <= RSP_CW'(`MSGQ_RSP_CREDITS);
		end else begin
			case ({o_rsp_valid, i_rsp_credit})
				2'b10: rsp_credits <= rsp_credits - 1'b1;
				2'b01: rsp_credits <= rsp_credits + 1'b1;
				default: rsp_credits <= rsp_credits;
			endcase
		end
	end

	bus_decoder u_dec (
		.core_clk(core_clk), .rst_n(rst_n), .i_req(req_head), .i_req_empty(req_empty),
		.o_req_pop(req_pop), .i_rsp_full(rsp_full), .o_rsp_push(rsp_push), .o_rsp(rsp_d),
		.o_q0_push(q0_push), .o_q0_pop(q0_pop), .o_q0_wdata(q0_wdata),
		.o_q1_push(q1_push), .o_q1_pop(q1_pop), .o_q1_wdata(q1_wdata),
		.i_q0_rdata(q0_rdata), .i_q1_rdata(q1_rdata),
		.i_q0_status(q0_status), .i_q1_status(q1_status),
		.o_sys_wr(sys_wr), .o_sys_rd(sys_rd), .o_sys_offset(sys_offset),
		.i_sys_rdata(sys_rdata), .i_sys_hit(sys_hit));

	sys_regs u_sys (
		.core_clk(core_clk), .rst_n(rst_n), .i_wr(sys_wr), .i_rd(sys_rd),
		.i_offset(sys_offset), .i_wdata(req_head.wdata),
		.i_q0_status(q0_status), .i_q1_status(q1_status), .o_rdata(sys_rdata),
		.o_hit(sys_hit), .o_q0_ctrl(q0_ctrl), .o_q1_ctrl(q1_ctrl),
		.o_led(o_led), .o_irq(o_irq));

	msg_queue u_q0 (
		.core_clk(core_clk), .rst_n(rst_n), .i_push(q0_push), .i_pop(q0_pop),
		.i_wdata(q0_wdata), .i_ctrl(q0_ctrl), .o_rdata(q0_rdata), .o_status(q0_status));

	msg_queue u_q1 (
		.core_clk(core_clk), .rst_n(rst_n), .i_push(q1_push), .i_pop(q1_pop),
		.i_wdata(q1_wdata), .i_ctrl(q1_ctrl), .o_rdata(q1_rdata), .o_status(q1_status));

endmodule

// File: tb_msgq_sys.sv
`include "msgq_macros.svh"

module tb_msgq_sys
	import bus_pkg::*;
();

	// seven words per vector in the data file
	localparam int VW = 7;
	localparam int MAX_VEC = 64;
	localparam int C_WR = 0;
	localparam int C_ADDR = 1;
	localparam int C_WDATA = 2;
	localparam int C_RDATA = 3;
	localparam int C_STATUS = 4;
	localparam int C_LED = 5;
	localparam int C_IRQ = 6;

	logic core_clk;
	logic rst_n;
	bus_req_t req;
	logic req_valid;
	logic req_credit;
	bus_rsp_t rsp;
	logic rsp_valid;
	logic rsp_credit;
	logic [3:0] led;
	logic irq;

	logic [31:0] vec_mem [VW*MAX_VEC];
	logic [31:0] lfsr;
	int due_q[$];
	int num_vec;
	int sent;
	int got;
	int retired;
	int state_idx;
	int host_credits;
	int dut_credits;
	int ready_cnt;
	int cycle;

	initial core_clk = 1'b0;
	always #4 core_clk = ~core_clk;

	msgq_sys_top dut (
		.core_clk(core_clk), .rst_n(rst_n), .i_req(req), .i_req_valid(req_valid),
		.o_req_credit(req_credit), .o_rsp(rsp), .o_rsp_valid(rsp_valid),
		.i_rsp_credit(rsp_credit), .o_led(led), .o_irq(irq));

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	task automatic report_mismatch(input string what, input int k, input logic [31:0] act,
		input logic [31:0] exp);
		$display("FAILED at time %0t: vector %0d %s is 0x%08h, expected 0x%08h",
			$time, k, what, act, exp);
		$display("Verification failed");
		$fatal(1, "output mismatch");
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at time %0t: %s", $time, why);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	task automatic compare_response(input int k);
		int base;
		base = k * VW;
		assert (32'(rsp.status) == vec_mem[base+C_STATUS])
			else report_mismatch("status", k, 32'(rsp.status), vec_mem[base+C_STATUS]);
		assert (rsp.rdata == vec_mem[base+C_RDATA])
			else report_mismatch("rdata", k, rsp.rdata, vec_mem[base+C_RDATA]);
	endtask

	// led and irq after request k and before any later one
	task automatic inspect_state(input int k);
		int base;
		base = k * VW;
		assert (led == vec_mem[base+C_LED][3:0])
			else report_mismatch("o_led", k, 32'(led), vec_mem[base+C_LED]);
		assert (irq == vec_mem[base+C_IRQ][0])
			else report_mismatch("o_irq", k, 32'(irq), vec_mem[base+C_IRQ]);
	endtask

	initial begin
		int delay;
		int keep[$];
		for (int i = 0; i < VW*MAX_VEC; i++) begin
			vec_mem[i] = 32'hffffffff;
		end
		$readmemh("msgq_vectors.txt", vec_mem);
		num_vec = 0;
		while (num_vec < MAX_VEC && vec_mem[num_vec*VW] != 32'hffffffff) begin
			num_vec++;
		end
		rst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		rsp_credit = 1'b0;
		lfsr = 32'h0eea610d;
		sent = 0;
		got = 0;
		retired = 0;
		state_idx = -1;
		host_credits = `MSGQ_REQ_CREDITS;
		dut_credits = `MSGQ_RSP_CREDITS;
		ready_cnt = 0;
		cycle = 0;
		if (num_vec == 0) begin
			abort_run("no vectors were read from msgq_vectors.txt");
		end
		repeat (4) @(posedge core_clk);
		@(negedge core_clk);
		assert (led == 4'd0 && !irq && !rsp_valid && !req_credit)
			else abort_run("outputs are not idle after reset");
		rst_n = 1'b1;

		while (got < num_vec) begin
			@(negedge core_clk);
			cycle++;
			if (cycle > 60 * num_vec) begin
				abort_run($sformatf("timeout, responses stopped arriving after %0d of %0d",
					got, num_vec));
			end
			if (state_idx >= 0) begin
				inspect_state(state_idx);
				state_idx = -1;
			end
			// credits come back in request order
			if (req_credit) begin
				host_credits++;
				assert (host_credits <= `MSGQ_REQ_CREDITS)
					else abort_run("host holds more request credits than it started with");
				state_idx = retired;
				retired++;
			end
			if (rsp_valid) begin
				assert (dut_credits > 0)
					else abort_run("a response was sent without a response credit");
				dut_credits--;
				compare_response(got);
				got++;
				delay = 0;
				repeat (2) begin
					lfsr = lfsr_step(lfsr);
					delay = delay * 2 + (lfsr[0] ? 1 : 0);
				end
				due_q.push_back(cycle + delay);
			end
			keep.delete();
			foreach (due_q[i]) begin
				if (due_q[i] <= cycle) begin
					ready_cnt++;
				end else begin
					keep.push_back(due_q[i]);
				end
			end
			due_q = keep;
			// at most one credit per cycle, the rest wait
			rsp_credit = (ready_cnt > 0);
			if (rsp_credit) begin
				ready_cnt--;
				dut_credits++;
			end
			if (sent < num_vec && host_credits > 0) begin
				req.is_write = vec_mem[sent*VW+C_WR][0];
				req.addr = vec_mem[sent*VW+C_ADDR][`MSGQ_ADDR_W-1:0];
				req.wdata = vec_mem[sent*VW+C_WDATA];
				req_valid = 1'b1;
				host_credits--;
				sent++;
			end else begin
				req_valid = 1'b0;
			end
		end

		// nothing more may come out once every request is answered
		repeat (8) begin
			@(negedge core_clk);
			rsp_credit = 1'b0;
			req_valid = 1'b0;
			assert (!rsp_valid) else abort_run("a response arrived with no request behind it");
			assert (!req_credit) else abort_run("a request credit came back with no request");
		end
		assert (retired == num_vec && host_credits == `MSGQ_REQ_CREDITS)
			else abort_run("not all request credits came back");
		$display("Verification passed");
		$finish;
	end

endmodule

// File: msgq_vectors.txt
// is_write addr wdata exp_rdata exp_status exp_led exp_irq
// status 0 ok, 1 empty, 2 full, 3 decode error
1 000 00000005 00000000 0 5 0
0 000 00000000 00000005 0 5 0
1 004 00000003 00000000 0 5 0
1 100 a0000001 00000000 0 5 1
1 100 a0000002 00000000 0 5 1
1 200 b0000001 00000000 0 5 1
0 104 00000000 00000002 0 5 1
0 008 00000000 00000003 0 5 1
0 100 00000000 a0000001 0 5 1
0 104 00000000 00000001 0 5 1
0 100 00000000 a0000002 0 5 1
0 100 00000000 00000000 1 5 1
1 004 00000001 00000000 0 5 0
0 200 00000000 b0000001 0 5 0
0 200 00000000 00000000 1 5 0
1 200 c0000001 00000000 0 5 0
1 200 c0000002 00000000 0 5 0
1 200 c0000003 00000000 0 5 0
1 200 c0000004 00000000 0 5 0
1 200 c0000005 00000000 0 5 0
1 200 c0000006 00000000 0 5 0
1 200 c0000007 00000000 0 5 0
1 200 c0000008 00000000 0 5 0
1 200 c0000009 00000000 2 5 0
0 204 00000000 00000008 0 5 0
1 204 12345678 00000000 0 5 0
1 004 00000002 00000000 0 5 1
1 100 d0000001 00000000 0 5 1
1 00c 00000002 00000000 0 5 0
0 204 00000000 00000000 0 5 0
0 200 00000000 00000000 1 5 0
0 104 00000000 00000001 0 5 0
0 010 00000000 00000000 3 5 0
1 300 ffffffff 00000000 3 5 0
1 008 00000003 00000000 3 5 0
0 00c 00000000 00000000 3 5 0
1 014 00000003 00000000 3 5 0
0 004 00000000 00000002 0 5 0
0 000 00000000 00000005 0 5 0

// File: verilog.f
+incdir+.
bus_pkg.sv
msgq_pkg.sv
credit_fifo.sv
msg_queue.sv
sys_regs.sv
bus_decoder.sv
msgq_sys_top.sv
tb_msgq_sys.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_msgq_sys -o sim_msgq; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_msgq)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Verification passed"; then
	exit 0
fi
exit 1
